/* Bender.yml */
package:
  name: enq_desc_queue

sources:
  - rtl/enq_desc_pkg.sv
  - rtl/sfifo_ctrl.sv
  - rtl/sfifo_ram.sv
  - rtl/enq_cfg_if.sv
  - rtl/enq_cfg_regs.sv
  - rtl/enq_admit.sv
  - rtl/enq_desc_queue.sv
  - target: test
    files:
      - tb/tb_enq_desc_queue.sv

/* enq_desc_queue.f */
rtl/enq_desc_pkg.sv
rtl/sfifo_ctrl.sv
rtl/sfifo_ram.sv
rtl/enq_cfg_if.sv
rtl/enq_cfg_regs.sv
rtl/enq_admit.sv
rtl/enq_desc_queue.sv
tb/tb_enq_desc_queue.sv

/* rtl/enq_admit.sv */
// admission decision for each enqueue strobe, purely combinational
// compares against the registered fifo count, so a dequeue in the
// same cycle gives no extra headroom until the next cycle
// a drop with the drop fifo full loses the pointer but still counts

`timescale 1ns/1ps

module enq_admit (
	input  logic                                   enq_valid,
	input  enq_desc_pkg::enq_pkt_desc_t            enq_desc,
	input  logic [enq_desc_pkg::DESC_DEPTH_NBITS:0] desc_count,
	input  logic                                   desc_full,
	input  logic                                   drop_full,
	output logic                                   desc_wr,
	output logic                                   drop_wr,
	output enq_desc_pkg::buf_ptr_t                 drop_ptr,
	enq_cfg_if.admit                               cfg
);

	// individual drop causes
	logic drop_disabled;
	logic drop_zero_len;
	logic drop_thresh;
	logic drop_no_room;
	logic drop_any;

	// ====================
	// drop causes
	// ====================

	// queue switched off by software
	assign drop_disabled = ~cfg.enable;

	// empty packets never enter the queue
	assign drop_zero_len = (enq_desc.pkt_len == '0);

	// fill level at or above the threshold
	// a threshold of 0 drops everything
	assign drop_thresh = (desc_count >= cfg.thresh);

	// hard limit, only matters when thresh is above the depth
	assign drop_no_room = desc_full;

	assign drop_any = drop_disabled | drop_zero_len | drop_thresh | drop_no_room;

	// ====================
	// routing
	// ====================

	// accepted descriptor goes to the descriptor fifo
	assign desc_wr = enq_valid & ~drop_any;

	// dropped pointer goes back through the drop fifo if there is space
	assign drop_wr  = enq_valid & drop_any & ~drop_full;
	assign drop_ptr = enq_desc.buf_ptr;

	// ====================
	// statistics pulses
	// ====================

	// same cycle as the fifo writes, so counters and fifos agree
	assign cfg.accept_inc = desc_wr;
	assign cfg.drop_inc   = enq_valid & drop_any;

endmodule

/* rtl/enq_cfg_if.sv */
// config and statistics link between register block and admission
// increment strobes are single cycle, one event each

`timescale 1ns/1ps

interface enq_cfg_if;

	// fill threshold, compared against the registered fifo count
	logic [enq_desc_pkg::DESC_DEPTH_NBITS:0] thresh;
	// queue enable
	logic                                    enable;

	// event pulses from admission
	logic accept_inc;
	logic drop_inc;

	// register side
	modport regs (
		output thresh,
		output enable,
		input  accept_inc,
		input  drop_inc
	);

	// admission side
	modport admit (
		input  thresh,
		input  enable,
		output accept_inc,
		output drop_inc
	);

endinterface

/* rtl/enq_cfg_regs.sv */
// threshold, enable and the accept and drop counters
// any write to a counter address clears that counter
// counters saturate at all ones
// read data returns one cycle after cfg_rd, valid with cfg_rvalid

`timescale 1ns/1ps

module enq_cfg_regs (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cfg_wr,
	input  logic                                cfg_rd,
	input  logic [enq_desc_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [enq_desc_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic                                cfg_rvalid,
	output logic [enq_desc_pkg::CFG_DATA_W-1:0] cfg_rdata,
	enq_cfg_if.regs                             cfg
);

	logic [enq_desc_pkg::DESC_DEPTH_NBITS:0] thresh_r;
	logic                                    enable_r;
	logic [enq_desc_pkg::CFG_DATA_W-1:0]     accept_cnt;
	logic [enq_desc_pkg::CFG_DATA_W-1:0]     drop_cnt;
	logic [enq_desc_pkg::CFG_DATA_W-1:0]     rdata_next;

	// ====================
	// config registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			thresh_r <= enq_desc_pkg::THRESH_RESET;
			enable_r <= 1'b1;
		end else if (cfg_wr) begin
			if (cfg_addr == enq_desc_pkg::CFG_ADDR_THRESH) begin
				thresh_r <= cfg_wdata[enq_desc_pkg::DESC_DEPTH_NBITS:0];
			end
			// enable sits in bit 0 of ctrl
			if (cfg_addr == enq_desc_pkg::CFG_ADDR_CTRL) begin
				enable_r <= cfg_wdata[0];
			end
		end
	end

	assign cfg.thresh = thresh_r;
	assign cfg.enable = enable_r;

	// ====================
	// statistics
	// ====================

	// clear takes priority over a same cycle increment
	always_ff @(posedge clk) begin
		if (rst) begin
			accept_cnt <= '0;
			drop_cnt   <= '0;
		end else begin
			if (cfg_wr && cfg_addr == enq_desc_pkg::CFG_ADDR_ACCEPT) begin
				accept_cnt <= '0;
			end else if (cfg.accept_inc && accept_cnt != '1) begin
				accept_cnt <= accept_cnt + 1'b1;
			end
			if (cfg_wr && cfg_addr == enq_desc_pkg::CFG_ADDR_DROP) begin
				drop_cnt <= '0;
			end else if (cfg.drop_inc && drop_cnt != '1) begin
				drop_cnt <= drop_cnt + 1'b1;
			end
		end
	end

	// ====================
	// read port
	// ====================

	// unused bits read as zero
	always_comb begin
		rdata_next = '0;
		case (cfg_addr)
			enq_desc_pkg::CFG_ADDR_THRESH: rdata_next[enq_desc_pkg::DESC_DEPTH_NBITS:0] = thresh_r;
			enq_desc_pkg::CFG_ADDR_CTRL:   rdata_next[0] = enable_r;
			enq_desc_pkg::CFG_ADDR_ACCEPT: rdata_next = accept_cnt;
			default:                       rdata_next = drop_cnt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_rvalid <= 1'b0;
		end else begin
			cfg_rvalid <= cfg_rd;
		end
	end

	// data only meaningful with cfg_rvalid
	always_ff @(posedge clk) begin
		if (cfg_rd) begin
			cfg_rdata <= rdata_next;
		end
	end

endmodule

/* rtl/enq_desc_pkg.sv */
// shared types and constants for the descriptor enqueue stage
// descriptor is packed as {buf_ptr, pkt_len, queue_id}, 34 bits in all
// register map uses word addresses 0 to 3 on a 2 bit address bus
// fifo depths are powers of two, given as log2

package enq_desc_pkg;

	// ====================
	// field widths
	// ====================

	localparam int BUF_PTR_W  = 16;
	localparam int PKT_LEN_W  = 14;
	localparam int QUEUE_ID_W = 4;

	// buffer pointer into the packet memory
	typedef logic [BUF_PTR_W-1:0] buf_ptr_t;

	// one packet descriptor as carried through the queue
	typedef struct packed {
		buf_ptr_t              buf_ptr;
		logic [PKT_LEN_W-1:0]  pkt_len;
		logic [QUEUE_ID_W-1:0] queue_id;
	} enq_pkt_desc_t;

	// ====================
	// fifo depths
	// ====================

	// 16 descriptor entries
	localparam int DESC_DEPTH_NBITS = 4;
	// 8 dropped pointers
	localparam int DROP_DEPTH_NBITS = 3;

	// ====================
	// register map
	// ====================

	localparam int CFG_ADDR_W = 2;
	localparam int CFG_DATA_W = 32;

	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_THRESH = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_CTRL   = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_ACCEPT = 2'd2;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_DROP   = 2'd3;

	// threshold out of reset equals the full descriptor fifo depth
	localparam logic [DESC_DEPTH_NBITS:0] THRESH_RESET = 1 << DESC_DEPTH_NBITS;

endpackage

/* rtl/enq_desc_queue.sv */
// enqueue stage of the packet buffer manager
// enq_valid can not be stalled, overflow turns into drops
// deq_rd and drop_rd return data one cycle later with the valid strobe
// queue_id is carried through only, there is a single queue

`timescale 1ns/1ps

module enq_desc_queue (
	input  logic                                      clk,
	input  logic                                      rst,
	// enqueue strobe
	input  logic                                      enq_valid,
	input  enq_desc_pkg::buf_ptr_t                    enq_buf_ptr,
	input  logic [enq_desc_pkg::PKT_LEN_W-1:0]        enq_pkt_len,
	input  logic [enq_desc_pkg::QUEUE_ID_W-1:0]       enq_queue_id,
	// dequeue to the scheduler
	input  logic                                      deq_rd,
	output logic                                      deq_valid,
	output enq_desc_pkg::buf_ptr_t                    deq_buf_ptr,
	output logic [enq_desc_pkg::PKT_LEN_W-1:0]        deq_pkt_len,
	output logic [enq_desc_pkg::QUEUE_ID_W-1:0]       deq_queue_id,
	output logic [enq_desc_pkg::DESC_DEPTH_NBITS:0]   desc_count,
	output logic                                      desc_empty,
	// dropped pointers back to the allocator
	input  logic                                      drop_rd,
	output logic                                      drop_valid,
	output enq_desc_pkg::buf_ptr_t                    drop_buf_ptr,
	output logic                                      drop_empty,
	// register port
	input  logic                                      cfg_wr,
	input  logic                                      cfg_rd,
	input  logic [enq_desc_pkg::CFG_ADDR_W-1:0]       cfg_addr,
	input  logic [enq_desc_pkg::CFG_DATA_W-1:0]       cfg_wdata,
	output logic                                      cfg_rvalid,
	output logic [enq_desc_pkg::CFG_DATA_W-1:0]       cfg_rdata
);

	enq_desc_pkg::enq_pkt_desc_t enq_desc;
	enq_desc_pkg::enq_pkt_desc_t deq_desc;
	enq_desc_pkg::buf_ptr_t      drop_ptr;
	logic                        desc_wr;
	logic                        desc_full;
	logic                        drop_wr;
	logic                        drop_full;

	enq_cfg_if u_cfg_if ();

	// ====================
	// descriptor packing
	// ====================

	assign enq_desc.buf_ptr  = enq_buf_ptr;
	assign enq_desc.pkt_len  = enq_pkt_len;
	assign enq_desc.queue_id = enq_queue_id;

	assign deq_buf_ptr  = deq_desc.buf_ptr;
	assign deq_pkt_len  = deq_desc.pkt_len;
	assign deq_queue_id = deq_desc.queue_id;

	// ====================
	// control blocks
	// ====================

	enq_cfg_regs u_cfg_regs (
		.clk        (clk),
		.rst        (rst),
		.cfg_wr     (cfg_wr),
		.cfg_rd     (cfg_rd),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rvalid (cfg_rvalid),
		.cfg_rdata  (cfg_rdata),
		.cfg        (u_cfg_if)
	);

	enq_admit u_admit (
		.enq_valid  (enq_valid),
		.enq_desc   (enq_desc),
		.desc_count (desc_count),
		.desc_full  (desc_full),
		.drop_full  (drop_full),
		.desc_wr    (desc_wr),
		.drop_wr    (drop_wr),
		.drop_ptr   (drop_ptr),
		.cfg        (u_cfg_if)
	);

	// ====================
	// fifos
	// ====================

	sfifo_ram #(
		.DEPTH_NBITS (enq_desc_pkg::DESC_DEPTH_NBITS),
		.payload_t   (enq_desc_pkg::enq_pkt_desc_t)
	) u_desc_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr         (desc_wr),
		.din        (enq_desc),
		.rd         (deq_rd),
		.dout       (deq_desc),
		.dout_valid (deq_valid),
		.count      (desc_count),
		.full       (desc_full),
		.empty      (desc_empty)
	);

	// drop fifo fill level is not exported
	sfifo_ram #(
		.DEPTH_NBITS (enq_desc_pkg::DROP_DEPTH_NBITS),
		.payload_t   (enq_desc_pkg::buf_ptr_t)
	) u_drop_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr         (drop_wr),
		.din        (drop_ptr),
		.rd         (drop_rd),
		.dout       (drop_buf_ptr),
		.dout_valid (drop_valid),
		.count      (),
		.full       (drop_full),
		.empty      (drop_empty)
	);

endmodule

/* rtl/sfifo_ctrl.sv */
// pointer and occupancy control for a single clock fifo
// reads on an empty fifo are dropped here
// writes are not checked, the caller must never write when full
// count runs from 0 to 2**DEPTH_NBITS

`timescale 1ns/1ps

module sfifo_ctrl #(
	parameter int DEPTH_NBITS = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd,
	input  logic                   wr,
	output logic [DEPTH_NBITS-1:0] rptr,
	output logic [DEPTH_NBITS-1:0] wptr,
	output logic [DEPTH_NBITS:0]   count,
	output logic                   full,
	output logic                   empty
);

	logic rd_eff;

	// underflow guard
	assign rd_eff = rd & ~empty;

	// ====================
	// pointers
	// ====================

	// both pointers wrap at the power of two depth
	always_ff @(posedge clk) begin
		if (rst) begin
			rptr <= '0;
			wptr <= '0;
		end else begin
			if (rd_eff) begin
				rptr <= rptr + 1'b1;
			end
			if (wr) begin
				wptr <= wptr + 1'b1;
			end
		end
	end

	// ====================
	// occupancy
	// ====================

	// read and write together leave the count as is
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({wr, rd_eff})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// count msb is only set at exactly full depth
	assign full  = count[DEPTH_NBITS];
	assign empty = (count == '0);

endmodule

/* rtl/sfifo_ram.sv */
// ram based single clock fifo, payload type given by parameter
// read data is registered, dout_valid pulses one cycle after rd
// rd on an empty fifo is ignored and gives no dout_valid
// no overflow check, writes to a full fifo must be blocked upstream

`timescale 1ns/1ps

module sfifo_ram #(
	parameter int  DEPTH_NBITS = 4,
	parameter type payload_t   = logic
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wr,
	input  payload_t             din,
	input  logic                 rd,
	output payload_t             dout,
	output logic                 dout_valid,
	output logic [DEPTH_NBITS:0] count,
	output logic                 full,
	output logic                 empty
);

	logic [DEPTH_NBITS-1:0] rptr;
	logic [DEPTH_NBITS-1:0] wptr;
	logic                   rd_eff;

	// storage, no reset
	payload_t mem [0:(1 << DEPTH_NBITS)-1];

	sfifo_ctrl #(
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_sfifo_ctrl (
		.clk   (clk),
		.rst   (rst),
		.rd    (rd),
		.wr    (wr),
		.rptr  (rptr),
		.wptr  (wptr),
		.count (count),
		.full  (full),
		.empty (empty)
	);

	// same qualification as inside the controller
	assign rd_eff = rd & ~empty;

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wptr] <= din;
		end
	end

	// head entry registered on an effective read
	always_ff @(posedge clk) begin
		if (rd_eff) begin
			dout <= mem[rptr];
		end
	end

	// one cycle valid pulse per read
	always_ff @(posedge clk) begin
		if (rst) begin
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= rd_eff;
		end
	end

endmodule

/* tb/tb_enq_desc_queue.sv */
// directed testbench for the descriptor enqueue stage
// expected values come from a reference model of the admission rule
// inputs change on the falling edge, outputs sampled there too
// first mismatch or timeout ends the run
// random fields from a 16 bit galois lfsr, seed 41

`timescale 1ns/1ps

module tb_enq_desc_queue;

	localparam int WAIT_LIMIT = 20;
	localparam int DESC_DEPTH = 1 << enq_desc_pkg::DESC_DEPTH_NBITS;
	localparam int DROP_DEPTH = 1 << enq_desc_pkg::DROP_DEPTH_NBITS;

	logic                                    clk;
	logic                                    rst;
	logic                                    enq_valid;
	enq_desc_pkg::buf_ptr_t                  enq_buf_ptr;
	logic [enq_desc_pkg::PKT_LEN_W-1:0]      enq_pkt_len;
	logic [enq_desc_pkg::QUEUE_ID_W-1:0]     enq_queue_id;
	logic                                    deq_rd;
	logic                                    deq_valid;
	enq_desc_pkg::buf_ptr_t                  deq_buf_ptr;
	logic [enq_desc_pkg::PKT_LEN_W-1:0]      deq_pkt_len;
	logic [enq_desc_pkg::QUEUE_ID_W-1:0]     deq_queue_id;
	logic [enq_desc_pkg::DESC_DEPTH_NBITS:0] desc_count;
	logic                                    desc_empty;
	logic                                    drop_rd;
	logic                                    drop_valid;
	enq_desc_pkg::buf_ptr_t                  drop_buf_ptr;
	logic                                    drop_empty;
	logic                                    cfg_wr;
	logic                                    cfg_rd;
	logic [enq_desc_pkg::CFG_ADDR_W-1:0]     cfg_addr;
	logic [enq_desc_pkg::CFG_DATA_W-1:0]     cfg_wdata;
	logic                                    cfg_rvalid;
	logic [enq_desc_pkg::CFG_DATA_W-1:0]     cfg_rdata;

	// ====================
	// reference model state
	// ====================

	logic [15:0]                 lfsr_state;
	enq_desc_pkg::enq_pkt_desc_t exp_q[$];
	enq_desc_pkg::buf_ptr_t      drop_q[$];
	int                          exp_thresh;
	logic                        exp_enable;
	int                          exp_accept;
	int                          exp_drop;

	enq_desc_queue uut (
		.clk          (clk),
		.rst          (rst),
		.enq_valid    (enq_valid),
		.enq_buf_ptr  (enq_buf_ptr),
		.enq_pkt_len  (enq_pkt_len),
		.enq_queue_id (enq_queue_id),
		.deq_rd       (deq_rd),
		.deq_valid    (deq_valid),
		.deq_buf_ptr  (deq_buf_ptr),
		.deq_pkt_len  (deq_pkt_len),
		.deq_queue_id (deq_queue_id),
		.desc_count   (desc_count),
		.desc_empty   (desc_empty),
		.drop_rd      (drop_rd),
		.drop_valid   (drop_valid),
		.drop_buf_ptr (drop_buf_ptr),
		.drop_empty   (drop_empty),
		.cfg_wr       (cfg_wr),
		.cfg_rd       (cfg_rd),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rvalid   (cfg_rvalid),
		.cfg_rdata    (cfg_rdata)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ====================
	// helpers
	// ====================

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			fail_stop($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic random_desc(output enq_desc_pkg::enq_pkt_desc_t d);
		logic [31:0] bits;
		take_bits(enq_desc_pkg::BUF_PTR_W, bits);
		d.buf_ptr = bits[enq_desc_pkg::BUF_PTR_W-1:0];
		take_bits(enq_desc_pkg::PKT_LEN_W, bits);
		d.pkt_len = bits[enq_desc_pkg::PKT_LEN_W-1:0];
		// keep random packets admissible
		if (d.pkt_len == '0) begin
			d.pkt_len = 1;
		end
		take_bits(enq_desc_pkg::QUEUE_ID_W, bits);
		d.queue_id = bits[enq_desc_pkg::QUEUE_ID_W-1:0];
	endtask

	// all strobes are single cycle
	task automatic release_strobes();
		enq_valid = 1'b0;
		deq_rd    = 1'b0;
		drop_rd   = 1'b0;
		cfg_wr    = 1'b0;
		cfg_rd    = 1'b0;
	endtask

	task automatic step();
		@(negedge clk);
		release_strobes();
	endtask

	// sel 0 deq_valid, 1 drop_valid, else cfg_rvalid
	// strobe must show up on the first sample after the request
	task automatic await_strobe(input int sel, input string name);
		logic seen;
		int   cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen) begin
			step();
			cycles++;
			case (sel)
				0: seen = deq_valid;
				1: seen = drop_valid;
				default: seen = cfg_rvalid;
			endcase
			if (!seen && cycles >= WAIT_LIMIT) begin
				fail_stop($sformatf("timeout, %s never went high", name));
			end
		end
		check_value({name, " latency"}, cycles, 1);
	endtask

	// admission rule applied to the model, count is the one before this strobe
	task automatic model_fifo(input enq_desc_pkg::enq_pkt_desc_t d);
		if (exp_enable && d.pkt_len != '0 && exp_q.size() < exp_thresh &&
				exp_q.size() < DESC_DEPTH) begin
			exp_q.push_back(d);
			exp_accept++;
		end else begin
			exp_drop++;
			// pointer lost once the drop fifo is full
			if (drop_q.size() < DROP_DEPTH) begin
				drop_q.push_back(d.buf_ptr);
			end
		end
	endtask

	// ====================
	// bus tasks
	// ====================

	task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
		step();
		cfg_wr    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
	endtask

	task automatic cfg_read_check(input logic [1:0] addr, input string name,
			input logic [31:0] exp);
		step();
		cfg_rd   = 1'b1;
		cfg_addr = addr;
		await_strobe(2, "cfg_rvalid");
		check_value(name, cfg_rdata, exp);
	endtask

	task automatic check_counters();
		cfg_read_check(enq_desc_pkg::CFG_ADDR_ACCEPT, "accept_cnt", exp_accept);
		cfg_read_check(enq_desc_pkg::CFG_ADDR_DROP, "drop_cnt", exp_drop);
	endtask

	// strobe stays up until the next step, so calls can run back to back
	task automatic enqueue_desc(input enq_desc_pkg::enq_pkt_desc_t d, input logic with_deq);
		step();
		enq_valid    = 1'b1;
		enq_buf_ptr  = d.buf_ptr;
		enq_pkt_len  = d.pkt_len;
		enq_queue_id = d.queue_id;
		deq_rd       = with_deq;
		model_fifo(d);
	endtask

	// deq_rd already issued in the current cycle
	task automatic expect_deq();
		enq_desc_pkg::enq_pkt_desc_t head;
		head = exp_q.pop_front();
		await_strobe(0, "deq_valid");
		check_value("deq_buf_ptr", deq_buf_ptr, head.buf_ptr);
		check_value("deq_pkt_len", deq_pkt_len, head.pkt_len);
		check_value("deq_queue_id", deq_queue_id, head.queue_id);
		check_value("desc_count", desc_count, exp_q.size());
		// valid for exactly one cycle
		step();
		check_value("deq_valid", deq_valid, 0);
	endtask

	task automatic drain_desc();
		while (exp_q.size() > 0) begin
			step();
			deq_rd = 1'b1;
			expect_deq();
		end
		check_value("desc_empty", desc_empty, 1);
	endtask

	task automatic drain_drop();
		enq_desc_pkg::buf_ptr_t ptr;
		while (drop_q.size() > 0) begin
			step();
			drop_rd = 1'b1;
			ptr = drop_q.pop_front();
			await_strobe(1, "drop_valid");
			check_value("drop_buf_ptr", drop_buf_ptr, ptr);
			step();
			check_value("drop_valid", drop_valid, 0);
		end
		check_value("drop_empty", drop_empty, 1);
	endtask

	// ====================
	// tests
	// ====================

	task automatic test_reset_state();
		check_value("desc_empty", desc_empty, 1);
		check_value("drop_empty", drop_empty, 1);
		check_value("desc_count", desc_count, 0);
		check_value("cfg_rvalid", cfg_rvalid, 0);
		cfg_read_check(enq_desc_pkg::CFG_ADDR_THRESH, "thresh", 16);
		cfg_read_check(enq_desc_pkg::CFG_ADDR_CTRL, "enable", 1);
		check_counters();
		repeat (3) begin
			step();
			check_value("deq_valid", deq_valid, 0);
			check_value("drop_valid", drop_valid, 0);
			check_value("cfg_rvalid", cfg_rvalid, 0);
		end
	endtask

	task automatic test_order_content();
		enq_desc_pkg::enq_pkt_desc_t d;
		for (int i = 0; i < 10; i++) begin
			random_desc(d);
			enqueue_desc(d, 1'b0);
			// count seen here excludes the strobe just issued
			check_value("desc_count", desc_count, i);
		end
		step();
		check_value("desc_count", desc_count, 10);
		check_value("desc_empty", desc_empty, 0);
		drain_desc();
		check_counters();
	endtask

	task automatic test_threshold_drops();
		enq_desc_pkg::enq_pkt_desc_t d;
		cfg_write(enq_desc_pkg::CFG_ADDR_THRESH, 4);
		exp_thresh = 4;
		for (int i = 0; i < 6; i++) begin
			random_desc(d);
			enqueue_desc(d, 1'b0);
		end
		step();
		check_value("desc_count", desc_count, 4);
		drain_drop();
		check_counters();
		drain_desc();
		// read on an empty queue is ignored
		step();
		deq_rd = 1'b1;
		repeat (3) begin
			step();
			check_value("deq_valid", deq_valid, 0);
		end
	endtask

	task automatic test_disable_zero_len();
		enq_desc_pkg::enq_pkt_desc_t d;
		cfg_write(enq_desc_pkg::CFG_ADDR_CTRL, 0);
		exp_enable = 1'b0;
		cfg_read_check(enq_desc_pkg::CFG_ADDR_CTRL, "enable", 0);
		for (int i = 0; i < 3; i++) begin
			random_desc(d);
			enqueue_desc(d, 1'b0);
		end
		step();
		check_value("desc_empty", desc_empty, 1);
		cfg_write(enq_desc_pkg::CFG_ADDR_CTRL, 1);
		exp_enable = 1'b1;
		random_desc(d);
		d.pkt_len = '0;
		enqueue_desc(d, 1'b0);
		random_desc(d);
		enqueue_desc(d, 1'b0);
		step();
		check_value("desc_count", desc_count, 1);
		check_counters();
		drain_drop();
		drain_desc();
		// any data clears
		cfg_write(enq_desc_pkg::CFG_ADDR_ACCEPT, 32'h5a5a_0001);
		cfg_write(enq_desc_pkg::CFG_ADDR_DROP, 32'hffff_ffff);
		exp_accept = 0;
		exp_drop   = 0;
		check_counters();
	endtask

	task automatic test_concurrency_overflow();
		enq_desc_pkg::enq_pkt_desc_t d;
		cfg_write(enq_desc_pkg::CFG_ADDR_THRESH, 16);
		exp_thresh = 16;
		for (int i = 0; i < DESC_DEPTH; i++) begin
			random_desc(d);
			enqueue_desc(d, 1'b0);
		end
		step();
		check_value("desc_count", desc_count, 16);
		// threshold above the depth, only the full flag can drop now
		cfg_write(enq_desc_pkg::CFG_ADDR_THRESH, 31);
		exp_thresh = 31;
		// full fifo, the dequeue gives no headroom in the same cycle
		random_desc(d);
		enqueue_desc(d, 1'b1);
		expect_deq();
		drain_drop();
		// 10 drops into an empty drop fifo of 8
		cfg_write(enq_desc_pkg::CFG_ADDR_CTRL, 0);
		exp_enable = 1'b0;
		for (int i = 0; i < 10; i++) begin
			random_desc(d);
			enqueue_desc(d, 1'b0);
		end
		step();
		check_value("drop_empty", drop_empty, 0);
		check_counters();
		drain_drop();
		step();
		drop_rd = 1'b1;
		repeat (3) begin
			step();
			check_value("drop_valid", drop_valid, 0);
		end
		cfg_write(enq_desc_pkg::CFG_ADDR_CTRL, 1);
		exp_enable = 1'b1;
		drain_desc();
		check_counters();
	endtask

	// ====================
	// main sequence
	// ====================

	initial begin
		rst          = 1'b1;
		enq_buf_ptr  = '0;
		enq_pkt_len  = '0;
		enq_queue_id = '0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		release_strobes();
		lfsr_state = 16'd41;
		exp_thresh = 16;
		exp_enable = 1'b1;
		exp_accept = 0;
		exp_drop   = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_reset_state();
		test_order_content();
		test_threshold_drops();
		test_disable_zero_len();
		test_concurrency_overflow();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
